//--- hdl/pl_pkg.sv
// Peripheral subsystem package with bus structs, address map, register offsets and reply codes
`default_nettype none

package pl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus geometry and address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int BUS_ADDR_WIDTH = 32;
    localparam int BUS_DATA_WIDTH = 32;

    localparam logic [BUS_ADDR_WIDTH-1:0] BASE_ADDR     = 32'h43C0_0000;
    localparam logic [BUS_ADDR_WIDTH-1:0] WINDOW_OFFSET = 32'h0001_0000;

    localparam int SLAVE_NUM = 2;
    localparam int UART_SLOT = 0;
    localparam int SPI_SLOT  = 1;

    // Clocks per UART bit and clocks per SPI half period
    localparam int UART_DIV_RESET = 16;
    localparam int SPI_DIV_RESET  = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register word offsets inside a window
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [1:0] REG_TXDATA = 2'd0;
    localparam logic [1:0] REG_STATUS = 2'd1;
    localparam logic [1:0] REG_RXDATA = 2'd2;
    localparam logic [1:0] REG_DIV    = 2'd3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request and response types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [15:0] win;
        logic [11:0] spare;
        logic [1:0]  reg_idx;
        logic [1:0]  byte_sel;
    } bus_addr_t;

    typedef struct packed {
        logic                      write;
        bus_addr_t                 addr;
        logic [BUS_DATA_WIDTH-1:0] wdata;
    } bus_req_t;

    // AXI response encoding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_code_t;

    typedef struct packed {
        resp_code_t                resp;
        logic [BUS_DATA_WIDTH-1:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

//--- hdl/axil_router.sv
// Register bus router that selects a peripheral window and returns one registered response
`timescale 1ns/1ps
`default_nettype none

module axil_router
    import pl_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     arst_n_i,

    input  logic                     req_valid_i,
    input  bus_req_t                 req_i,
    output logic                     req_ready_o,

    output logic                     rsp_valid_o,
    output bus_rsp_t                 rsp_o,
    input  logic                     rsp_ready_i,

    output logic     [SLAVE_NUM-1:0] slv_sel_o,
    output bus_req_t                 slv_req_o,
    input  logic     [SLAVE_NUM-1:0] slv_ack_i,
    input  bus_rsp_t [SLAVE_NUM-1:0] slv_rsp_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESP
    } state_t;

    state_t               state_q;
    logic [SLAVE_NUM-1:0] hit;
    logic                 take;
    logic                 miss_q;
    logic                 miss_ack_q;
    logic                 any_ack;
    bus_rsp_t             ack_rsp;

    // Upper half of the window base address for a slot
    function automatic logic [15:0] window_num(input int unsigned slot);
        logic [BUS_ADDR_WIDTH-1:0] base;
        base = BASE_ADDR + slot * WINDOW_OFFSET;
        return base[31:16];
    endfunction

    assign req_ready_o = (state_q == ST_IDLE);
    assign rsp_valid_o = (state_q == ST_RESP);
    assign take        = req_valid_i & req_ready_o;

    always_comb begin
        for (int i = 0; i < SLAVE_NUM; i++) begin
            hit[i] = (req_i.addr.win == window_num(i));
        end
    end

    // A miss behaves like a virtual slave that acks with DECERR
    always_comb begin
        any_ack = miss_ack_q;
        ack_rsp = '{resp: RESP_DECERR, rdata: '0};
        for (int i = 0; i < SLAVE_NUM; i++) begin
            if (slv_ack_i[i]) begin
                any_ack = 1'b1;
                ack_rsp = slv_rsp_i[i];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake controller
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            slv_sel_o  <= '0;
            miss_q     <= 1'b0;
            miss_ack_q <= 1'b0;
        end else begin
            slv_sel_o  <= '0;
            miss_q     <= 1'b0;
            miss_ack_q <= miss_q;
            case (state_q)
                ST_IDLE: begin
                    if (take) begin
                        slv_sel_o <= hit;
                        miss_q    <= ~|hit;
                        state_q   <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (any_ack) begin
                        state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (rsp_ready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            slv_req_o <= req_i;
        end
        if (state_q == ST_WAIT && any_ack) begin
            rsp_o <= ack_rsp;
        end
    end

endmodule

`default_nettype wire

//--- hdl/uart_tx_regs.sv
// UART transmitter with data, status and divisor registers on the peripheral bus
`timescale 1ns/1ps
`default_nettype none

module uart_tx_regs
    import pl_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     sel_i,
    input  bus_req_t req_i,
    output logic     ack_o,
    output bus_rsp_t rsp_o,

    output logic     uart_tx_o
);

    logic [15:0]               div_q;
    logic [15:0]               baud_cnt_q;
    logic [3:0]                bit_cnt_q;
    logic [9:0]                frame_q;
    logic                      busy_q;

    logic                      wr_tx;
    logic                      wr_div;
    logic                      baud_tick;
    logic [BUS_DATA_WIDTH-1:0] rd_data;

    assign wr_tx     = sel_i & req_i.write & (req_i.addr.reg_idx == REG_TXDATA);
    assign wr_div    = sel_i & req_i.write & (req_i.addr.reg_idx == REG_DIV);
    assign baud_tick = busy_q & ((baud_cnt_q + 16'd1) >= div_q);

    // Frame register idles at all ones so the line stays high
    assign uart_tx_o = frame_q[0];

    always_comb begin
        rd_data = '0;
        case (req_i.addr.reg_idx)
            REG_STATUS: rd_data[0]    = busy_q;
            REG_DIV:    rd_data[15:0] = div_q;
            default:    rd_data       = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame engine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_q      <= 16'(UART_DIV_RESET);
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            frame_q    <= '1;
            busy_q     <= 1'b0;
            ack_o      <= 1'b0;
        end else begin
            ack_o <= sel_i;
            if (wr_div) begin
                div_q <= req_i.wdata[15:0];
            end
            if (wr_tx && !busy_q) begin
                // Stop, data LSB first, start
                frame_q    <= {1'b1, req_i.wdata[7:0], 1'b0};
                busy_q     <= 1'b1;
                baud_cnt_q <= '0;
                bit_cnt_q  <= '0;
            end else if (busy_q) begin
                if (baud_tick) begin
                    baud_cnt_q <= '0;
                    if (bit_cnt_q == 4'd9) begin
                        busy_q <= 1'b0;
                    end else begin
                        frame_q   <= {1'b1, frame_q[9:1]};
                        bit_cnt_q <= bit_cnt_q + 4'd1;
                    end
                end else begin
                    baud_cnt_q <= baud_cnt_q + 16'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rsp_o.resp  <= (wr_tx && busy_q) ? RESP_SLVERR : RESP_OKAY;
            rsp_o.rdata <= req_i.write ? '0 : rd_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/spi_master_regs.sv
// Mode-0 SPI master with data, status, receive and divisor registers on the peripheral bus
`timescale 1ns/1ps
`default_nettype none

module spi_master_regs
    import pl_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     sel_i,
    input  bus_req_t req_i,
    output logic     ack_o,
    output bus_rsp_t rsp_o,

    output logic     spi_clk_o,
    output logic     spi_mosi_o,
    output logic     spi_cs_o,
    input  logic     spi_miso_i
);

    logic [15:0]               div_q;
    logic [15:0]               half_cnt_q;
    logic [3:0]                edge_cnt_q;
    logic [7:0]                shift_q;
    logic [7:0]                rx_q;
    logic                      busy_q;
    logic                      sclk_q;
    logic                      mosi_q;
    logic                      cs_q;

    logic                      wr_tx;
    logic                      wr_div;
    logic                      half_tick;
    logic [BUS_DATA_WIDTH-1:0] rd_data;

    assign wr_tx     = sel_i & req_i.write & (req_i.addr.reg_idx == REG_TXDATA);
    assign wr_div    = sel_i & req_i.write & (req_i.addr.reg_idx == REG_DIV);
    assign half_tick = busy_q & ((half_cnt_q + 16'd1) >= div_q);

    assign spi_clk_o  = sclk_q;
    assign spi_mosi_o = mosi_q;
    assign spi_cs_o   = cs_q;

    always_comb begin
        rd_data = '0;
        case (req_i.addr.reg_idx)
            REG_STATUS: rd_data[0]    = busy_q;
            REG_RXDATA: rd_data[7:0]  = rx_q;
            REG_DIV:    rd_data[15:0] = div_q;
            default:    rd_data       = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transfer engine of 16 half periods per byte
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_q      <= 16'(SPI_DIV_RESET);
            half_cnt_q <= '0;
            edge_cnt_q <= '0;
            shift_q    <= '0;
            rx_q       <= '0;
            busy_q     <= 1'b0;
            sclk_q     <= 1'b0;
            mosi_q     <= 1'b0;
            cs_q       <= 1'b1;
            ack_o      <= 1'b0;
        end else begin
            ack_o <= sel_i;
            if (wr_div) begin
                div_q <= req_i.wdata[15:0];
            end
            if (wr_tx && !busy_q) begin
                // First bit is on MOSI before the first rising edge
                shift_q    <= req_i.wdata[7:0];
                mosi_q     <= req_i.wdata[7];
                cs_q       <= 1'b0;
                busy_q     <= 1'b1;
                half_cnt_q <= '0;
                edge_cnt_q <= '0;
            end else if (busy_q) begin
                if (half_tick) begin
                    half_cnt_q <= '0;
                    edge_cnt_q <= edge_cnt_q + 4'd1;
                    sclk_q     <= ~sclk_q;
                    if (!sclk_q) begin
                        // Rising edge samples MISO
                        shift_q <= {shift_q[6:0], spi_miso_i};
                    end else if (edge_cnt_q == 4'd15) begin
                        rx_q   <= shift_q;
                        mosi_q <= 1'b0;
                        cs_q   <= 1'b1;
                        busy_q <= 1'b0;
                    end else begin
                        mosi_q <= shift_q[7];
                    end
                end else begin
                    half_cnt_q <= half_cnt_q + 16'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rsp_o.resp  <= (wr_tx && busy_q) ? RESP_SLVERR : RESP_OKAY;
            rsp_o.rdata <= req_i.write ? '0 : rd_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pl_periph_top.sv
// Peripheral subsystem top joining the address router, UART transmitter and SPI master
`timescale 1ns/1ps
`default_nettype none

module pl_periph_top
    import pl_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     req_valid_i,
    input  bus_req_t req_i,
    output logic     req_ready_o,

    output logic     rsp_valid_o,
    output bus_rsp_t rsp_o,
    input  logic     rsp_ready_i,

    output logic     uart_tx_o,

    output logic     spi_clk_o,
    output logic     spi_mosi_o,
    output logic     spi_cs_o,
    input  logic     spi_miso_i
);

    logic     [SLAVE_NUM-1:0] slv_sel;
    logic     [SLAVE_NUM-1:0] slv_ack;
    bus_req_t                 slv_req;
    bus_rsp_t [SLAVE_NUM-1:0] slv_rsp;

    axil_router i_axil_router (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .req_valid_i(req_valid_i),
        .req_i      (req_i),
        .req_ready_o(req_ready_o),
        .rsp_valid_o(rsp_valid_o),
        .rsp_o      (rsp_o),
        .rsp_ready_i(rsp_ready_i),
        .slv_sel_o  (slv_sel),
        .slv_req_o  (slv_req),
        .slv_ack_i  (slv_ack),
        .slv_rsp_i  (slv_rsp)
    );

    // Window 0
    uart_tx_regs i_uart_tx_regs (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .sel_i    (slv_sel[UART_SLOT]),
        .req_i    (slv_req),
        .ack_o    (slv_ack[UART_SLOT]),
        .rsp_o    (slv_rsp[UART_SLOT]),
        .uart_tx_o(uart_tx_o)
    );

    // Window 1
    spi_master_regs i_spi_master_regs (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .sel_i     (slv_sel[SPI_SLOT]),
        .req_i     (slv_req),
        .ack_o     (slv_ack[SPI_SLOT]),
        .rsp_o     (slv_rsp[SPI_SLOT]),
        .spi_clk_o (spi_clk_o),
        .spi_mosi_o(spi_mosi_o),
        .spi_cs_o  (spi_cs_o),
        .spi_miso_i(spi_miso_i)
    );

endmodule

`default_nettype wire

//--- sim/tb_models.svh
// Bus access tasks, UART line decoder and register reference model for the peripheral testbench
`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference register model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

logic [15:0] uart_div_m;
logic [15:0] spi_div_m;
logic [7:0]  spi_rx_m;
logic        uart_busy_m;
logic        spi_busy_m;

// Window index of an address or -1 outside the map
function automatic int window_of(input logic [31:0] addr);
    if (addr[31:16] == UART_BASE[31:16]) return 0;
    if (addr[31:16] == SPI_BASE[31:16]) return 1;
    return -1;
endfunction

function automatic logic [31:0] reg_addr(input int win, input logic [1:0] idx);
    return (win == 0 ? UART_BASE : SPI_BASE) | {28'd0, idx, 2'b00};
endfunction

function automatic bus_rsp_t expect_rsp(input logic wr, input logic [31:0] addr);
    bus_rsp_t   r;
    int         win;
    logic [1:0] idx;
    win     = window_of(addr);
    idx     = addr[3:2];
    r.resp  = RESP_OKAY;
    r.rdata = '0;
    if (win < 0) begin
        r.resp = RESP_DECERR;
    end else if (wr) begin
        if (idx == REG_TXDATA && (win == 0 ? uart_busy_m : spi_busy_m)) begin
            r.resp = RESP_SLVERR;
        end
    end else if (idx == REG_DIV) begin
        r.rdata = {16'd0, (win == 0 ? uart_div_m : spi_div_m)};
    end else if (idx == REG_RXDATA && win == 1) begin
        r.rdata = {24'd0, spi_rx_m};
    end
    return r;
endfunction

function automatic void model_write(input logic [31:0] addr, input logic [31:0] wdata);
    int win;
    win = window_of(addr);
    if (win >= 0 && addr[3:2] == REG_DIV) begin
        if (win == 0) uart_div_m = wdata[15:0];
        else spi_div_m = wdata[15:0];
    end else if (win == 0 && addr[3:2] == REG_TXDATA && !uart_busy_m) begin
        uart_busy_m = 1'b1;
    end else if (win == 1 && addr[3:2] == REG_TXDATA && !spi_busy_m) begin
        spi_busy_m = 1'b1;
        // MISO is looped back from MOSI
        spi_rx_m   = wdata[7:0];
    end
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Starts and ends on a falling edge and holds the response for a random time
task automatic bus_access(input logic wr, input logic [31:0] addr,
                          input logic [31:0] wdata, output bus_rsp_t rsp);
    int n;
    int hold;
    hold = $urandom_range(0, 4);
    n    = 0;
    while (!req_ready && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
    end
    if (!req_ready) abort_on_timeout("request channel never became ready");
    req_valid  = 1'b1;
    req.write  = wr;
    req.addr   = addr;
    req.wdata  = wdata;
    @(negedge clk);
    req_valid = 1'b0;
    check_equal("ready after handshake", req_ready, 0);
    n = 1;
    while (!rsp_valid && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
    end
    if (!rsp_valid) abort_on_timeout("no response after a request");
    // Two clock edges from handshake to response show on the third falling edge
    check_equal("response latency", n, 3);
    rsp = rsp_o;
    repeat (hold) begin
        @(negedge clk);
        check_equal("held response valid", rsp_valid, 1);
        check_equal("held response", rsp_o, rsp);
        check_equal("ready while response held", req_ready, 0);
    end
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
    check_equal("ready after response", req_ready, 1);
endtask

task automatic checked_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output bus_rsp_t rsp);
    bus_rsp_t exp;
    exp = expect_rsp(wr, addr);
    bus_access(wr, addr, wdata, rsp);
    check_equal("response code", rsp.resp, exp.resp);
    // STATUS busy depends on transfer timing outside the model
    if (wr || window_of(addr) < 0 || addr[3:2] != REG_STATUS) begin
        check_equal("response data", rsp.rdata, exp.rdata);
    end
    if (wr) model_write(addr, wdata);
endtask

task automatic poll_idle(input int win);
    bus_rsp_t r;
    int       n;
    n = 0;
    checked_access(1'b0, reg_addr(win, REG_STATUS), '0, r);
    while (r.rdata[0] && n < POLL_LIMIT) begin
        checked_access(1'b0, reg_addr(win, REG_STATUS), '0, r);
        n++;
    end
    if (r.rdata[0]) abort_on_timeout("peripheral stayed busy");
    if (win == 0) uart_busy_m = 1'b0;
    else spi_busy_m = 1'b0;
endtask

// Samples each UART bit near its middle by counting from the falling start edge
task automatic uart_decode(input int div, output logic [7:0] data);
    int n;
    n = 0;
    while (uart_tx && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
    end
    if (uart_tx) abort_on_timeout("no UART start bit");
    repeat (div / 2) @(negedge clk);
    check_equal("UART start bit", uart_tx, 0);
    for (int i = 0; i < 8; i++) begin
        repeat (div) @(negedge clk);
        data[i] = uart_tx;
    end
    repeat (div) @(negedge clk);
    check_equal("UART stop bit", uart_tx, 1);
endtask

`endif

//--- sim/tb_pl_periph.sv
// Testbench for the peripheral subsystem with random register traffic against a register model
`timescale 1ns/1ps
`default_nettype none

module tb_pl_periph
    import pl_pkg::*;
();

    localparam int          SEED       = 84623;
    localparam int          CLK_PERIOD = 40;
    localparam int          WAIT_LIMIT = 2000;
    localparam int          POLL_LIMIT = 300;
    localparam int          N_DIV      = 4;
    localparam int          N_XFER     = 3;
    localparam int          N_DECERR   = 6;
    localparam logic [31:0] UART_BASE  = 32'h43C0_0000;
    localparam logic [31:0] SPI_BASE   = 32'h43C1_0000;

    logic     clk;
    logic     arst_n;
    logic     req_valid;
    bus_req_t req;
    logic     req_ready;
    logic     rsp_valid;
    bus_rsp_t rsp_o;
    logic     rsp_ready;
    logic     uart_tx;
    logic     spi_clk;
    logic     spi_mosi;
    logic     spi_cs;
    logic     spi_miso;

    int mismatches = 0;
    int failures   = 0;

    assign spi_miso = spi_mosi;

    pl_periph_top pl_periph_top_i (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .req_valid_i(req_valid),
        .req_i      (req),
        .req_ready_o(req_ready),
        .rsp_valid_o(rsp_valid),
        .rsp_o      (rsp_o),
        .rsp_ready_i(rsp_ready),
        .uart_tx_o  (uart_tx),
        .spi_clk_o  (spi_clk),
        .spi_mosi_o (spi_mosi),
        .spi_cs_o   (spi_cs),
        .spi_miso_i (spi_miso)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0d ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
        end
    endtask

    task automatic report_and_finish();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string why);
        failures++;
        $display("timeout at %0d ns: %s", $time, why);
        report_and_finish();
    endtask

    `include "tb_models.svh"

    // Counts rising SPI clock edges and shifts in MOSI at each while chip select is low
    task automatic spi_watch(output int rises, output logic [7:0] mosi_byte);
        logic prev;
        int   n;
        n         = 0;
        rises     = 0;
        mosi_byte = '0;
        while (spi_cs && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (spi_cs) abort_on_timeout("SPI chip select never went low");
        prev = spi_clk;
        while (!spi_cs && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (!prev && spi_clk && !spi_cs) begin
                rises++;
                mosi_byte = {mosi_byte[6:0], spi_mosi};
            end
            prev = spi_clk;
            n++;
        end
        if (!spi_cs) abort_on_timeout("SPI chip select stuck low");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        bus_rsp_t    r;
        logic [31:0] addr;
        logic [7:0]  b;
        logic [7:0]  got;
        logic [7:0]  sent;
        int          rises;
        arst_n      = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        rsp_ready   = 1'b0;
        uart_div_m  = 16'd16;
        spi_div_m   = 16'd4;
        spi_rx_m    = '0;
        uart_busy_m = 1'b0;
        spi_busy_m  = 1'b0;
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // Idle state and reset divisors
        check_equal("idle req_ready", req_ready, 1);
        check_equal("idle rsp_valid", rsp_valid, 0);
        check_equal("idle uart_tx", uart_tx, 1);
        check_equal("idle spi_cs", spi_cs, 1);
        check_equal("idle spi_clk", spi_clk, 0);
        check_equal("idle spi_mosi", spi_mosi, 0);
        checked_access(1'b0, reg_addr(0, REG_DIV), '0, r);
        checked_access(1'b0, reg_addr(1, REG_DIV), '0, r);

        // Divisor read-back with ignored writes to STATUS and RXDATA
        for (int i = 0; i < N_DIV; i++) begin
            checked_access(1'b1, reg_addr(0, REG_DIV), $urandom_range(2, 31), r);
            checked_access(1'b1, reg_addr(0, REG_STATUS), $urandom, r);
            checked_access(1'b0, reg_addr(0, REG_DIV), '0, r);
            checked_access(1'b1, reg_addr(1, REG_DIV), $urandom_range(2, 31), r);
            checked_access(1'b1, reg_addr(1, REG_RXDATA), $urandom, r);
            checked_access(1'b0, reg_addr(1, REG_DIV), '0, r);
        end

        for (int i = 0; i < N_XFER; i++) begin
            b = 8'($urandom);
            fork
                checked_access(1'b1, reg_addr(0, REG_TXDATA), {24'd0, b}, r);
                uart_decode(uart_div_m, got);
            join
            check_equal("UART data byte", got, b);
            poll_idle(0);
        end

        for (int i = 0; i < N_XFER; i++) begin
            b = 8'($urandom);
            fork
                checked_access(1'b1, reg_addr(1, REG_TXDATA), {24'd0, b}, r);
                spi_watch(rises, sent);
            join
            check_equal("SPI clock rising edges", rises, 8);
            check_equal("SPI MOSI byte", sent, b);
            poll_idle(1);
            checked_access(1'b0, reg_addr(1, REG_RXDATA), '0, r);
        end

        // Second write while busy
        for (int w = 0; w < 2; w++) begin
            checked_access(1'b1, reg_addr(w, REG_TXDATA), $urandom, r);
            checked_access(1'b1, reg_addr(w, REG_TXDATA), $urandom, r);
            poll_idle(w);
        end
        checked_access(1'b0, reg_addr(1, REG_RXDATA), '0, r);

        for (int i = 0; i < N_DECERR; i++) begin
            addr = $urandom;
            if (window_of(addr) >= 0) addr[31] = ~addr[31];
            checked_access(1'($urandom_range(0, 1)), addr, $urandom, r);
        end

        report_and_finish();
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+sim
hdl/pl_pkg.sv
hdl/axil_router.sv
hdl/uart_tx_regs.sv
hdl/spi_master_regs.sv
hdl/pl_periph_top.sv
sim/tb_pl_periph.sv

//--- Bender.yml
package:
  name: pl_periph

sources:
  - hdl/pl_pkg.sv
  - hdl/axil_router.sv
  - hdl/uart_tx_regs.sv
  - hdl/spi_master_regs.sv
  - hdl/pl_periph_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_pl_periph.sv
